//--- delta_cfg_regs.sv
//##########################################################################
// Configuration registers for the delta path
// Holds the output layer index and the ReLU derivative enable
//##########################################################################
`timescale 1ns/100ps

module delta_cfg_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_wr,
    input  logic                 cfg_addr,
    input  nn_delta_pkg::delta_t cfg_wdata,
    output nn_delta_pkg::delta_t cfg_rdata,
    output nn_delta_pkg::layer_t output_layer,
    output logic                 relu_en
);

    import nn_delta_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            output_layer <= OUTPUT_LAYER_RST;
            relu_en      <= 1'b1;                         // Mask on by default
        end else if (cfg_wr) begin
            case (cfg_addr)
                CFG_ADDR_OUTPUT_LAYER: output_layer <= cfg_wdata[LAYER_W-1:0];
                CFG_ADDR_RELU_EN:      relu_en      <= cfg_wdata[0];
                default: ;
            endcase
        end
    end

    // Readback mux, zero-extended to the data width
    always_comb begin
        case (cfg_addr)
            CFG_ADDR_OUTPUT_LAYER: cfg_rdata = delta_t'(output_layer);
            CFG_ADDR_RELU_EN:      cfg_rdata = delta_t'(relu_en);
            default:               cfg_rdata = '0;
        endcase
    end

endmodule

//--- delta_clk_gen.sv
//##########################################################################
// Testbench clock source, free-running with a 20 ns period
//##########################################################################
`timescale 1ns/100ps

module delta_clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

//--- delta_path.f
nn_delta_pkg.sv
delta_cfg_regs.sv
error_fetcher.sv
delta_propagator.sv
delta_picker.sv
delta_path_top.sv
delta_clk_gen.sv
delta_path_tb.sv

//--- delta_path_tb.sv
//##########################################################################
// Testbench for the delta-selection path
// Directed and random streams checked against one queue per delta source
//##########################################################################
`timescale 1ns/100ps

module delta_path_tb;

    import nn_delta_pkg::*;

    localparam int  NUM_TXN      = 60;
    localparam int  WORST_CYCLES = 150;
    localparam time WATCHDOG_NS  = NUM_TXN * WORST_CYCLES * 20 + 20_000;  // 200 us
    localparam int  RAND_N       = 40;

    logic    clk;
    logic    rst;
    logic    cfg_wr;
    logic    cfg_addr;
    delta_t  cfg_wdata;
    delta_t  cfg_rdata;
    delta_t  act;
    delta_t  target;
    logic    err_valid;
    logic    err_ready;
    delta_t  next_delta;
    weight_t weight;
    delta_t  prop_act;
    logic    prop_valid;
    logic    prop_ready;
    layer_t  layer;
    logic    layer_valid;
    logic    layer_ready;
    delta_t  result;
    logic    result_valid;
    logic    result_ready;

    delta_t  fetch_q[$];                 // Expected error deltas in arrival order
    delta_t  prop_q[$];                  // Expected propagated deltas
    layer_t  layer_q[$];                 // Accepted layer requests
    layer_t  cur_out_layer;
    logic    cur_relu;
    logic    rand_rdy;
    int      err_cnt;
    int      res_cnt;
    int      pass_cnt;
    int      fail_cnt;

    delta_clk_gen u_clk (.clk(clk));

    delta_path_top uut (.*);

    // Held result must not move while the consumer stalls
    assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else begin
            err_cnt++;
            $display("Result changed or dropped while stalled at %0t", $time);
        end

    assert property (@(posedge clk)
        $fell(rst) |-> err_ready && prop_ready && layer_ready && !result_valid)
        else begin
            err_cnt++;
            $display("Handshakes not idle right after reset at %0t", $time);
        end

    // Expected hidden-layer delta from Q.8 times Q8.8 with the ReLU' mask
    function automatic delta_t prop_ref(input delta_t d, input weight_t w, input delta_t a,
                                        input logic relu);
        longint p;
        p = longint'(d) * longint'(w);
        p = p >>> 8;
        if (relu && a <= 0) begin
            return '0;
        end
        return delta_t'(p);
    endfunction

    task automatic check_result(input delta_t got);
        layer_t l;
        delta_t exp;
        res_cnt++;
        if (layer_q.size() == 0) begin
            err_cnt++;
            $display("Result at %0t arrived with no layer request pending", $time);
            return;
        end
        l = layer_q.pop_front();
        if (l == cur_out_layer && fetch_q.size() > 0) begin
            exp = fetch_q.pop_front();
        end else if (l != cur_out_layer && prop_q.size() > 0) begin
            exp = prop_q.pop_front();
        end else begin
            err_cnt++;
            $display("Result for layer %0d at %0t has no delta to match", l, $time);
            return;
        end
        assert (got == exp) else begin
            err_cnt++;
            $display("Mismatch at %0t: layer %0d gave %0h, expected %0h", $time, l, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && layer_valid && layer_ready) begin
            layer_q.push_back(layer);
        end
        if (!rst && result_valid && result_ready) begin
            check_result(result);
        end
    end

    task automatic send_err(input delta_t a, input delta_t t, input int gap);
        @(negedge clk);
        repeat (gap) @(negedge clk);
        act       = a;
        target    = t;
        err_valid = 1'b1;
        fetch_q.push_back(a - t);                 // MSE derivative
        @(posedge clk);
        while (!err_ready) @(posedge clk);
        @(negedge clk);
        err_valid = 1'b0;
    endtask

    task automatic send_prop(input delta_t d, input weight_t w, input delta_t a, input int gap);
        @(negedge clk);
        repeat (gap) @(negedge clk);
        next_delta = d;
        weight     = w;
        prop_act   = a;
        prop_valid = 1'b1;
        prop_q.push_back(prop_ref(d, w, a, cur_relu));
        @(posedge clk);
        while (!prop_ready) @(posedge clk);
        @(negedge clk);
        prop_valid = 1'b0;
    endtask

    task automatic send_layer(input layer_t l, input int gap);
        @(negedge clk);
        repeat (gap) @(negedge clk);
        layer       = l;
        layer_valid = 1'b1;
        @(posedge clk);
        while (!layer_ready) @(posedge clk);
        @(negedge clk);
        layer_valid = 1'b0;
    endtask

    task automatic write_cfg(input logic addr, input delta_t data);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr = 1'b0;
        if (addr == 1'b0) begin
            cur_out_layer = data[1:0];
        end else begin
            cur_relu = data[0];
        end
    endtask

    task automatic check_cfg(input logic addr, input delta_t exp);
        @(negedge clk);
        cfg_addr = addr;
        @(posedge clk);
        assert (cfg_rdata == exp) else begin
            err_cnt++;
            $display("Mismatch at %0t: register %0d reads %0h, expected %0h",
                     $time, addr, cfg_rdata, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            fail_cnt++;
            $display("[%0t] %s: FAILED with %0d errors", $time, name, err_cnt - errs_before);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0t", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int          base;
        int          nf;
        layer_t      lay_list[RAND_N];
        void'($urandom(32'h725));
        rst = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = 1'b0;
        cfg_wdata = '0;
        act = '0;
        target = '0;
        err_valid = 1'b0;
        next_delta = '0;
        weight = '0;
        prop_act = '0;
        prop_valid = 1'b0;
        layer = '0;
        layer_valid = 1'b0;
        result_ready = 1'b1;
        rand_rdy = 1'b0;
        cur_out_layer = 2'd3;                      // Reset value of the output layer
        cur_relu = 1'b1;
        err_cnt = 0;
        res_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        fork
            forever begin
                @(negedge clk);
                result_ready = rand_rdy ? ($urandom % 3 != 0) : 1'b1;  // Random stalls
            end
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        base = err_cnt;
        @(posedge clk);
        assert (!result_valid && err_ready && prop_ready && layer_ready) else begin
            err_cnt++;
            $display("Streams not idle after reset at %0t", $time);
        end
        check_cfg(1'b0, 32'd3);
        check_cfg(1'b1, 32'd1);
        end_test("reset and readback", base);

        base = err_cnt;
        send_err(32'sh500, 32'sh200, 0);
        send_layer(2'd3, 0);
        send_err(32'sh100, 32'sh380, 0);           // Negative error
        send_layer(2'd3, 0);
        send_err(-32'sh40, 32'sh7f, 1);
        send_layer(2'd3, 0);
        wait (res_cnt >= 3);
        end_test("output layer error", base);

        base = err_cnt;
        send_prop(32'sh300, 16'sh0180, 32'sd5, 0);
        send_layer(2'd0, 0);
        send_prop(-32'sh200, 16'sh0100, 32'sd1, 0);
        send_layer(2'd1, 0);
        send_prop(32'sh400, 16'sh0200, 32'sd0, 0); // Zero activation is masked
        send_layer(2'd2, 0);
        send_prop(32'sh400, -16'sh0080, -32'sd7, 0);
        send_layer(2'd0, 0);
        wait (res_cnt >= 7);
        end_test("hidden layer propagation", base);

        base = err_cnt;
        write_cfg(1'b0, 32'd1);
        write_cfg(1'b1, 32'd0);
        check_cfg(1'b0, 32'd1);
        check_cfg(1'b1, 32'd0);
        send_err(32'sh80, 32'sh180, 0);
        send_layer(2'd1, 0);
        send_prop(32'sh200, 16'sh0300, -32'sd9, 0); // Unmasked with ReLU' off
        send_layer(2'd3, 0);
        send_prop(-32'sh123, 16'sh00c0, 32'sd2, 0);
        send_layer(2'd0, 0);
        wait (res_cnt >= 10);
        end_test("reconfigured output layer", base);

        base = err_cnt;
        write_cfg(1'b1, 32'd1);
        nf = 0;
        foreach (lay_list[i]) begin
            lay_list[i] = layer_t'($urandom % 4);
            nf += (lay_list[i] == cur_out_layer);
        end
        rand_rdy = 1'b1;
        fork
            foreach (lay_list[i]) send_layer(lay_list[i], $urandom % 4);
            repeat (nf) send_err($urandom, $urandom, $urandom % 4);
            repeat (RAND_N - nf) send_prop($urandom, weight_t'($urandom),
                                           ($urandom % 4 == 0) ? 32'd0 : $urandom, $urandom % 4);
        join
        wait (res_cnt >= 10 + RAND_N);
        rand_rdy = 1'b0;
        repeat (20) @(posedge clk);
        assert (res_cnt == 10 + RAND_N && layer_q.size() == 0 &&
                fetch_q.size() == 0 && prop_q.size() == 0) else begin
            err_cnt++;
            $display("Results lost or repeated in the random run: %0d seen", res_cnt);
        end
        end_test("random streams", base);

        $display("Tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- delta_path_top.sv
//##########################################################################
// Delta-selection path top level
// Configuration registers, error fetcher, propagator and picker
//##########################################################################
`timescale 1ns/100ps

module delta_path_top (
    input  logic                  clk,
    input  logic                  rst,
    // Configuration port
    input  logic                  cfg_wr,
    input  logic                  cfg_addr,
    input  nn_delta_pkg::delta_t  cfg_wdata,
    output nn_delta_pkg::delta_t  cfg_rdata,
    // Error stream
    input  nn_delta_pkg::delta_t  act,
    input  nn_delta_pkg::delta_t  target,
    input  logic                  err_valid,
    output logic                  err_ready,
    // Propagation stream
    input  nn_delta_pkg::delta_t  next_delta,
    input  nn_delta_pkg::weight_t weight,
    input  nn_delta_pkg::delta_t  prop_act,
    input  logic                  prop_valid,
    output logic                  prop_ready,
    // Layer request stream
    input  nn_delta_pkg::layer_t  layer,
    input  logic                  layer_valid,
    output logic                  layer_ready,
    // Result stream
    output nn_delta_pkg::delta_t  result,
    output logic                  result_valid,
    input  logic                  result_ready
);

    import nn_delta_pkg::*;

    layer_t output_layer;
    logic   relu_en;
    delta_t fetch_delta;
    logic   fetch_valid;
    logic   fetch_ready;
    delta_t prop_delta;
    logic   prop_delta_valid;
    logic   prop_delta_ready;

    delta_cfg_regs u_cfg (
        .clk(clk), .rst(rst),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .output_layer(output_layer), .relu_en(relu_en)
    );

    error_fetcher u_fetch (
        .clk(clk), .rst(rst),
        .act(act), .target(target), .err_valid(err_valid), .err_ready(err_ready),
        .fetch_delta(fetch_delta), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready)
    );

    delta_propagator u_prop (
        .clk(clk), .rst(rst), .relu_en(relu_en),
        .next_delta(next_delta), .weight(weight), .prop_act(prop_act),
        .prop_valid(prop_valid), .prop_ready(prop_ready),
        .prop_delta(prop_delta), .prop_delta_valid(prop_delta_valid),
        .prop_delta_ready(prop_delta_ready)
    );

    delta_picker u_pick (
        .clk(clk), .rst(rst), .output_layer(output_layer),
        .layer(layer), .layer_valid(layer_valid), .layer_ready(layer_ready),
        .fetch_delta(fetch_delta), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .prop_delta(prop_delta), .prop_delta_valid(prop_delta_valid),
        .prop_delta_ready(prop_delta_ready),
        .result(result), .result_valid(result_valid), .result_ready(result_ready)
    );

endmodule

//--- delta_picker.sv
//##########################################################################
// Delta picker
// Holds a layer request and one delta from each source, returns the
// fetcher delta for the output layer and the propagated one otherwise
//##########################################################################
`timescale 1ns/100ps

module delta_picker (
    input  logic                 clk,
    input  logic                 rst,
    input  nn_delta_pkg::layer_t output_layer,
    input  nn_delta_pkg::layer_t layer,
    input  logic                 layer_valid,
    output logic                 layer_ready,
    input  nn_delta_pkg::delta_t fetch_delta,
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    input  nn_delta_pkg::delta_t prop_delta,
    input  logic                 prop_delta_valid,
    output logic                 prop_delta_ready,
    output nn_delta_pkg::delta_t result,
    output logic                 result_valid,
    input  logic                 result_ready
);

    import nn_delta_pkg::*;

    picker_state_t state;

    layer_t layer_buf;
    delta_t fetch_buf;
    delta_t prop_buf;
    logic   layer_held;
    logic   fetch_held;
    logic   prop_held;
    logic   sel_fetch;                 // Source chosen for the pending result
    logic   want_fetch;
    logic   pick_go;
    logic   done_xfer;

    // Each slot accepts only while empty
    assign layer_ready      = !layer_held;
    assign fetch_ready      = !fetch_held;
    assign prop_delta_ready = !prop_held;

    assign want_fetch = (layer_buf == output_layer);
    assign pick_go    = layer_held && (want_fetch ? fetch_held : prop_held);
    assign done_xfer  = (state == PICK_DONE) && result_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= PICK_IDLE;
            sel_fetch  <= 1'b0;
            layer_held <= 1'b0;
            fetch_held <= 1'b0;
            prop_held  <= 1'b0;
        end else begin
            case (state)
                PICK_IDLE: begin
                    if (pick_go) begin
                        state     <= PICK_DONE;
                        sel_fetch <= want_fetch;     // Freeze selection
                    end
                end
                PICK_DONE: begin
                    if (result_ready) begin
                        state <= PICK_IDLE;
                    end
                end
                default: state <= PICK_IDLE;
            endcase

            // Held flags; a capture only happens on an empty slot
            if (layer_valid && layer_ready) begin
                layer_held <= 1'b1;
            end else if (done_xfer) begin
                layer_held <= 1'b0;
            end
            if (fetch_valid && fetch_ready) begin
                fetch_held <= 1'b1;
            end else if (done_xfer && sel_fetch) begin
                fetch_held <= 1'b0;
            end
            if (prop_delta_valid && prop_delta_ready) begin
                prop_held <= 1'b1;
            end else if (done_xfer && !sel_fetch) begin
                prop_held <= 1'b0;
            end
        end
    end

    // Buffers load at their transfer edge
    always_ff @(posedge clk) begin
        if (layer_valid && layer_ready) begin
            layer_buf <= layer;
        end
        if (fetch_valid && fetch_ready) begin
            fetch_buf <= fetch_delta;
        end
        if (prop_delta_valid && prop_delta_ready) begin
            prop_buf <= prop_delta;
        end
    end

    assign result       = sel_fetch ? fetch_buf : prop_buf;
    assign result_valid = (state == PICK_DONE);

endmodule

//--- delta_propagator.sv
//##########################################################################
// Hidden-layer delta propagator, two-stage pipeline
// Stage 1 multiplies delta by weight, stage 2 rescales and applies ReLU'
//##########################################################################
`timescale 1ns/100ps

module delta_propagator (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  relu_en,
    input  nn_delta_pkg::delta_t  next_delta,
    input  nn_delta_pkg::weight_t weight,
    input  nn_delta_pkg::delta_t  prop_act,
    input  logic                  prop_valid,
    output logic                  prop_ready,
    output nn_delta_pkg::delta_t  prop_delta,
    output logic                  prop_delta_valid,
    input  logic                  prop_delta_ready
);

    import nn_delta_pkg::*;

    logic   advance;
    prod_t  product;
    prod_t  s1_prod;
    logic   s1_pos;
    logic   s1_valid;
    prod_t  prod_shifted;
    delta_t scaled;

    // Whole pipe moves together; it stops only when stage 2 is stuck
    assign advance    = !prop_delta_valid || prop_delta_ready;
    assign prop_ready = advance;

    assign product = next_delta * weight;                  // Signed, full width

    // Stage 1 valid and stage 2 valid
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid         <= 1'b0;
            prop_delta_valid <= 1'b0;
        end else if (advance) begin
            s1_valid         <= prop_valid;
            prop_delta_valid <= s1_valid;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_prod <= product;
            s1_pos  <= (prop_act > 0);                     // ReLU derivative flag
        end
    end

    // Back to Q.8 and down to delta width
    assign prod_shifted = s1_prod >>> FRAC_BITS;
    assign scaled       = delta_t'(prod_shifted);

    // Stage 2 payload with the derivative mask
    always_ff @(posedge clk) begin
        if (advance) begin
            if (relu_en && !s1_pos) begin
                prop_delta <= '0;
            end else begin
                prop_delta <= scaled;
            end
        end
    end

endmodule

//--- error_fetcher.sv
//##########################################################################
// Output-layer error unit
// Computes act - target (MSE derivative) into a one-entry output register
//##########################################################################
`timescale 1ns/100ps

module error_fetcher (
    input  logic                 clk,
    input  logic                 rst,
    input  nn_delta_pkg::delta_t act,
    input  nn_delta_pkg::delta_t target,
    input  logic                 err_valid,
    output logic                 err_ready,
    output nn_delta_pkg::delta_t fetch_delta,
    output logic                 fetch_valid,
    input  logic                 fetch_ready
);

    import nn_delta_pkg::*;

    delta_t err_diff;
    logic   load;

    assign err_diff  = act - target;
    assign err_ready = !fetch_valid || fetch_ready;  // Empty, or drained this cycle
    assign load      = err_valid && err_ready;

    // Valid flag of the output register
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else if (load) begin
            fetch_valid <= 1'b1;
        end else if (fetch_ready) begin
            fetch_valid <= 1'b0;
        end
    end

    // Payload of the output register
    always_ff @(posedge clk) begin
        if (load) begin
            fetch_delta <= err_diff;
        end
    end

endmodule

//--- nn_delta_pkg.sv
//##########################################################################
// Shared definitions for the backpropagation delta-selection path
// Widths, fixed-point format, register map and configuration reset values
//##########################################################################

package nn_delta_pkg;

    // Activations, targets and deltas
    localparam int DELTA_W   = 32;
    localparam int FRAC_BITS = 8;              // Fraction bits in both formats

    typedef logic signed [DELTA_W-1:0] delta_t;

    // Weights in Q8.8
    localparam int WEIGHT_W = 16;

    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // Full delta x weight product
    localparam int PROD_W = DELTA_W + WEIGHT_W;

    typedef logic signed [PROD_W-1:0] prod_t;

    // Layer index
    localparam int LAYER_W = 2;

    typedef logic [LAYER_W-1:0] layer_t;

    // Configuration register map and reset values
    localparam layer_t OUTPUT_LAYER_RST      = 2'd3;
    localparam logic   CFG_ADDR_OUTPUT_LAYER = 1'b0;
    localparam logic   CFG_ADDR_RELU_EN      = 1'b1;

    // Picker FSM
    typedef enum logic {
        PICK_IDLE,
        PICK_DONE
    } picker_state_t;

endpackage
